// File: design/vout_defines.svh
// video output stage
// width constants

`ifndef VOUT_DEFINES_SVH
`define VOUT_DEFINES_SVH

// palette RAM geometry, fixed by the DAC
`define VOUT_CRAM_AW 8
`define VOUT_CRAM_DW 16

// dither pattern length in half-cycle slots
`define VOUT_PWM_W 8

`endif

// File: design/vout_pkg.sv
// video output stage types

`include "vout_defines.svh"

package vout_pkg;

  // cpu side palette write, one entry per strobe
  typedef struct packed {
    logic                     we;
    logic [`VOUT_CRAM_AW-1:0] addr;
    logic [`VOUT_CRAM_DW-1:0] data;
  } cram_wr_t;

  // one colour channel, coarse dac level over fine pwm intensity
  typedef struct packed {
    logic [1:0] coarse;
    logic [2:0] fine;
  } chan_t;

  typedef struct packed {
    logic  mode;
    chan_t red;
    chan_t green;
    chan_t blue;
  } pal_entry_t;

  // per-source video controls
  typedef struct packed {
    logic blank;
    logic hires;
    logic nib_sel;
    logic line_par;
  } vid_ctrl_t;

  typedef struct packed {
    logic [1:0] r;
    logic [1:0] g;
    logic [1:0] b;
  } dac_rgb_t;

  // first half-cycle sample in the upper bits
  typedef struct packed {
    dac_rgb_t first;
    dac_rgb_t second;
  } dac_pair_t;

  // dither patterns by fine intensity
  localparam logic [`VOUT_PWM_W-1:0] pwm_table [8] = '{
    8'b00000000, 8'b00000001, 8'b01000001, 8'b01000101,
    8'b10100101, 8'b10100111, 8'b11010111, 8'b11011111
  };

endpackage

// File: design/vout_src_select.sv
// pixel source and palette address select

`timescale 1ns/10ps

`include "vout_defines.svh"

module vout_src_select
  import vout_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tv_strobe,
  input  logic                     vga_on,
  input  logic [`VOUT_CRAM_AW-1:0] tv_index,
  input  logic [`VOUT_CRAM_AW-1:0] vga_index,
  input  vid_ctrl_t                tv_ctrl,
  input  vid_ctrl_t                vga_ctrl,
  input  logic [3:0]               pal_page,
  output logic [`VOUT_CRAM_AW-1:0] pal_addr,
  output logic                     blank,
  output logic                     line_par
);

  logic [`VOUT_CRAM_AW-1:0] tv_index_q;
  logic [`VOUT_CRAM_AW-1:0] sel_index;
  vid_ctrl_t                sel_ctrl;
  logic [3:0]               sel_nibble;

  // tv pixels arrive slower than clk, hold between strobes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tv_index_q <= '0;
    end
    else if (tv_strobe)
    begin
      tv_index_q <= tv_index;
    end
  end

  always_comb
  begin
    if (vga_on)
    begin
      sel_index = vga_index;
      sel_ctrl  = vga_ctrl;
    end
    else
    begin
      sel_index = tv_index_q;
      sel_ctrl  = tv_ctrl;
    end
  end

  // hires packs two pixels per index, nib_sel=1 picks the low one
  assign sel_nibble = sel_ctrl.nib_sel ? sel_index[3:0] : sel_index[7:4];

  always_comb
  begin
    if (sel_ctrl.hires)
      pal_addr = {pal_page, sel_nibble};
    else
      pal_addr = sel_index;
  end

  assign blank    = sel_ctrl.blank;
  assign line_par = sel_ctrl.line_par;

  // source select must be a clean level once running
  a_vga_on_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(vga_on)
  ) else $error("vga_on unknown out of reset");

endmodule

// File: design/vout_palette_ram.sv
// palette RAM, 256 x 16

`timescale 1ns/10ps

`include "vout_defines.svh"

module vout_palette_ram
  import vout_pkg::*;
(
  input  logic                     clk,
  input  cram_wr_t                 cram_wr,
  input  logic [`VOUT_CRAM_AW-1:0] rd_addr,
  output pal_entry_t               rd_data
);

  logic [`VOUT_CRAM_DW-1:0] mem [2**`VOUT_CRAM_AW];
  logic [`VOUT_CRAM_DW-1:0] rd_q;

  // cpu write port
  always_ff @(posedge clk)
  begin
    if (cram_wr.we)
    begin
      mem[cram_wr.addr] <= cram_wr.data;
    end
  end

  // pixel read port, old data on a same-address write
  always_ff @(posedge clk)
  begin
    rd_q <= mem[rd_addr];
  end

  assign rd_data = pal_entry_t'(rd_q);

  a_wr_addr_known: assert property (
    @(posedge clk)
    cram_wr.we |-> !$isunknown(cram_wr.addr)
  ) else $error("palette write with unknown address");

endmodule

// File: design/vout_pwm_dither.sv
// blanking and pwm dither for the narrow DAC
// raw rgb passes out for the wide DAC

`timescale 1ns/10ps

`include "vout_defines.svh"

module vout_pwm_dither
  import vout_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       vga_on,
  input  logic       blank,
  input  logic       line_par,
  input  pal_entry_t pal_rd,
  output pal_entry_t pix_raw,
  output dac_pair_t  dac_out
);

  logic      blank_q;
  logic [1:0] ph;
  logic [1:0] phase;
  logic [2:0] idx_first;
  logic [2:0] idx_second;
  dac_pair_t  dac_d;

  // one channel, step the coarse level up when the pattern slot is set
  function automatic logic [1:0] dither_chan(input chan_t c, input logic [2:0] bit_idx);
    logic [`VOUT_PWM_W-1:0] pat;
    pat = pwm_table[c.fine];
    if (pat[bit_idx] && (c.coarse != 2'd3))
      return c.coarse + 2'd1;
    else
      return c.coarse;
  endfunction

  // blank lines up with the ram read
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      blank_q <= 1'b0;
    end
    else
    begin
      blank_q <= blank;
    end
  end

  // mode bit goes through, dac still needs it in blanking
  always_comb
  begin
    pix_raw = pal_rd;
    if (blank_q)
    begin
      pix_raw.red   = '0;
      pix_raw.green = '0;
      pix_raw.blue  = '0;
    end
  end

  // free-running pwm phase
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ph <= 2'd0;
    end
    else
    begin
      ph <= ph + 2'd1;
    end
  end

  // vga alternates the pattern half per line instead
  assign phase      = {vga_on ? line_par : ph[1], ph[0]};
  assign idx_first  = {phase, 1'b0};
  assign idx_second = {phase, 1'b1};

  always_comb
  begin
    dac_d.first.r  = dither_chan(pix_raw.red, idx_first);
    dac_d.first.g  = dither_chan(pix_raw.green, idx_first);
    dac_d.first.b  = dither_chan(pix_raw.blue, idx_first);
    dac_d.second.r = dither_chan(pix_raw.red, idx_second);
    dac_d.second.g = dither_chan(pix_raw.green, idx_second);
    dac_d.second.b = dither_chan(pix_raw.blue, idx_second);
  end

  // both half-cycle samples for the external ddr cell
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dac_out <= '0;
    end
    else
    begin
      dac_out <= dac_d;
    end
  end

  // blank requested at the source shows up as black one cycle later
  a_blank_black: assert property (
    @(posedge clk) disable iff (!rst_n)
    ($past(rst_n) && $past(blank)) |->
      (pix_raw.red == '0 && pix_raw.green == '0 && pix_raw.blue == '0)
  ) else $error("blanked pixel has nonzero rgb");

  // saturated coarse level is never dithered
  a_coarse_sat: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pix_raw.red.coarse == 2'd3) |=>
      (dac_out.first.r == 2'd3 && dac_out.second.r == 2'd3)
  ) else $error("red coarse 3 altered by dither");

  a_coarse_sat_g: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pix_raw.green.coarse == 2'd3) |=>
      (dac_out.first.g == 2'd3 && dac_out.second.g == 2'd3)
  ) else $error("green coarse 3 altered by dither");

  a_coarse_sat_b: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pix_raw.blue.coarse == 2'd3) |=>
      (dac_out.first.b == 2'd3 && dac_out.second.b == 2'd3)
  ) else $error("blue coarse 3 altered by dither");

endmodule

// File: design/vout_top.sv
// video pixel output stage

`timescale 1ns/10ps

`include "vout_defines.svh"

module vout_top
  import vout_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tv_strobe,
  input  logic                     vga_on,
  input  logic [`VOUT_CRAM_AW-1:0] tv_index,
  input  logic [`VOUT_CRAM_AW-1:0] vga_index,
  input  vid_ctrl_t                tv_ctrl,
  input  vid_ctrl_t                vga_ctrl,
  input  logic [3:0]               pal_page,
  input  cram_wr_t                 cram_wr,
  output pal_entry_t               pix_raw,
  output dac_pair_t                dac_out
);

  logic [`VOUT_CRAM_AW-1:0] pal_addr;
  logic                     blank;
  logic                     line_par;
  pal_entry_t               pal_rd;

  // index, controls and palette address
  vout_src_select src_select_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .tv_strobe (tv_strobe),
    .vga_on    (vga_on),
    .tv_index  (tv_index),
    .vga_index (vga_index),
    .tv_ctrl   (tv_ctrl),
    .vga_ctrl  (vga_ctrl),
    .pal_page  (pal_page),
    .pal_addr  (pal_addr),
    .blank     (blank),
    .line_par  (line_par)
  );

  // palette lookup, one cycle
  vout_palette_ram palette_ram_i (
    .clk     (clk),
    .cram_wr (cram_wr),
    .rd_addr (pal_addr),
    .rd_data (pal_rd)
  );

  // blanking, raw and dithered outputs
  vout_pwm_dither pwm_dither_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .vga_on   (vga_on),
    .blank    (blank),
    .line_par (line_par),
    .pal_rd   (pal_rd),
    .pix_raw  (pix_raw),
    .dac_out  (dac_out)
  );

endmodule

// File: bench/vout_checker.sv
// output checker for the video stage

`timescale 1ns/10ps

`include "vout_defines.svh"

module vout_checker
  import vout_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     tv_strobe,
  input  logic                     vga_on,
  input  logic [`VOUT_CRAM_AW-1:0] tv_index,
  input  logic [`VOUT_CRAM_AW-1:0] vga_index,
  input  vid_ctrl_t                tv_ctrl,
  input  vid_ctrl_t                vga_ctrl,
  input  logic [3:0]               pal_page,
  input  cram_wr_t                 cram_wr,
  input  pal_entry_t               pix_raw,
  input  dac_pair_t                dac_out,
  output int                       error_count,
  output int                       check_count
);

  logic [`VOUT_CRAM_DW-1:0] shadow [2**`VOUT_CRAM_AW];
  logic [`VOUT_CRAM_AW-1:0] tv_q;
  logic [1:0]               ph;
  vid_ctrl_t                ctrl;
  logic [`VOUT_CRAM_AW-1:0] index;
  logic [`VOUT_CRAM_AW-1:0] addr;
  logic [1:0]               phase;
  pal_entry_t               exp_pix;
  logic                     pix_known;
  dac_pair_t                exp_dac;
  logic                     dac_known;

  // expected raw pixel, mode bit survives blanking
  function automatic pal_entry_t blank_pixel(input pal_entry_t e, input logic blk);
    pal_entry_t p;
    p = e;
    if (blk)
      p = {e.mode, 15'd0};
    return p;
  endfunction

  // coarse in c[4:3], fine in c[2:0]
  function automatic logic [1:0] dither_ref(input logic [4:0] c, input int slot);
    logic [`VOUT_PWM_W-1:0] pat;
    pat = pwm_table[c[2:0]];
    if (pat[slot] == 1'b1 && c[4:3] < 2'd3)
      return c[4:3] + 2'd1;
    return c[4:3];
  endfunction

  function automatic dac_pair_t expect_dac(input pal_entry_t p, input logic [1:0] phase_in);
    dac_pair_t d;
    int        s0;
    s0 = 2 * phase_in;
    d.first.r  = dither_ref(p.red, s0);
    d.first.g  = dither_ref(p.green, s0);
    d.first.b  = dither_ref(p.blue, s0);
    d.second.r = dither_ref(p.red, s0 + 1);
    d.second.g = dither_ref(p.green, s0 + 1);
    d.second.b = dither_ref(p.blue, s0 + 1);
    return d;
  endfunction

  initial
  begin
    error_count = 0;
    check_count = 0;
  end

  // model pipeline, advanced on the DUT's clock edge
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      tv_q      = '0;
      ph        = 2'd0;
      pix_known = 1'b0;
      exp_dac   = '0;
      dac_known = 1'b1;
    end
    else
    begin
      ctrl  = vga_on ? vga_ctrl : tv_ctrl;
      index = vga_on ? vga_index : tv_q;
      // last cycle's pixel meets this cycle's phase
      phase     = {(vga_on ? ctrl.line_par : ph[1]), ph[0]};
      exp_dac   = expect_dac(exp_pix, phase);
      dac_known = pix_known && !$isunknown({exp_pix.red, exp_pix.green, exp_pix.blue});
      if (ctrl.hires)
        addr = ctrl.nib_sel ? {pal_page, index[3:0]} : {pal_page, index[7:4]};
      else
        addr = index;
      // read before write, so a same-address write gives the old entry
      exp_pix   = blank_pixel(shadow[addr], ctrl.blank);
      pix_known = 1'b1;
      if (cram_wr.we)
        shadow[cram_wr.addr] = cram_wr.data;
      if (tv_strobe)
        tv_q = tv_index;
      ph = ph + 2'd1;
    end
  end

  // outputs are settled half a cycle after the edge
  always @(negedge clk)
  begin
    if (pix_known === 1'b1 && !$isunknown(exp_pix))
    begin
      check_count++;
      if (pix_raw !== exp_pix)
      begin
        error_count++;
        $display("ERROR t=%0t pix_raw expected %h got %h", $time, exp_pix, pix_raw);
      end
    end
    if (dac_known === 1'b1)
    begin
      check_count++;
      if (dac_out !== exp_dac)
      begin
        error_count++;
        $display("ERROR t=%0t dac_out expected %h got %h", $time, exp_dac, dac_out);
      end
    end
  end

endmodule

// File: bench/vout_tb.sv
// testbench for the video output stage

`timescale 1ns/10ps

`include "vout_defines.svh"

module vout_tb
  import vout_pkg::*;
();

  localparam int NUM_PIXELS      = 4000;
  localparam int WATCHDOG_CYCLES = 20000;

  logic                     clk;
  logic                     rst_n;
  logic                     tv_strobe;
  logic                     vga_on;
  logic [`VOUT_CRAM_AW-1:0] tv_index;
  logic [`VOUT_CRAM_AW-1:0] vga_index;
  vid_ctrl_t                tv_ctrl;
  vid_ctrl_t                vga_ctrl;
  logic [3:0]               pal_page;
  cram_wr_t                 cram_wr;
  pal_entry_t               pix_raw;
  dac_pair_t                dac_out;
  int                       error_count;
  int                       check_count;
  logic                     stim_done;
  int unsigned              seed_val;

  vout_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .tv_strobe (tv_strobe),
    .vga_on    (vga_on),
    .tv_index  (tv_index),
    .vga_index (vga_index),
    .tv_ctrl   (tv_ctrl),
    .vga_ctrl  (vga_ctrl),
    .pal_page  (pal_page),
    .cram_wr   (cram_wr),
    .pix_raw   (pix_raw),
    .dac_out   (dac_out)
  );

  vout_checker checker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .tv_strobe   (tv_strobe),
    .vga_on      (vga_on),
    .tv_index    (tv_index),
    .vga_index   (vga_index),
    .tv_ctrl     (tv_ctrl),
    .vga_ctrl    (vga_ctrl),
    .pal_page    (pal_page),
    .cram_wr     (cram_wr),
    .pix_raw     (pix_raw),
    .dac_out     (dac_out),
    .error_count (error_count),
    .check_count (check_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // quiet inputs, TV source blanked
  task automatic drive_idle();
    tv_strobe = 1'b0;
    vga_on    = 1'b0;
    tv_index  = '0;
    vga_index = '0;
    tv_ctrl   = '{blank: 1'b1, default: 1'b0};
    vga_ctrl  = '0;
    pal_page  = '0;
    cram_wr   = '0;
  endtask

  // one entry per cycle while the output stays blanked
  task automatic load_palette();
    for (int i = 0; i < 2**`VOUT_CRAM_AW; i++)
    begin
      @(negedge clk);
      cram_wr.we   = 1'b1;
      cram_wr.addr = i[`VOUT_CRAM_AW-1:0];
      cram_wr.data = $urandom_range(16'hffff);
      tv_strobe    = $urandom_range(1);
      tv_index     = $urandom_range(255);
    end
    @(negedge clk);
    cram_wr.we = 1'b0;
  endtask

  task automatic drive_random_pixel();
    vga_on         = $urandom_range(1);
    tv_strobe      = ($urandom_range(3) == 0);
    tv_index       = $urandom_range(255);
    vga_index      = $urandom_range(255);
    tv_ctrl        = vid_ctrl_t'($urandom_range(15));
    vga_ctrl       = vid_ctrl_t'($urandom_range(15));
    tv_ctrl.blank  = ($urandom_range(7) == 0);
    vga_ctrl.blank = ($urandom_range(7) == 0);
    pal_page       = $urandom_range(15);
    cram_wr.we     = ($urandom_range(7) == 0);
    cram_wr.addr   = $urandom_range(255);
    cram_wr.data   = $urandom_range(16'hffff);
    // some writes hit the address being read
    if (cram_wr.we && vga_on && !vga_ctrl.hires && $urandom_range(1))
      cram_wr.addr = vga_index;
  endtask

  initial
  begin
    seed_val  = $urandom(32'he82f1d38);
    stim_done = 1'b0;
    rst_n     = 1'b0;
    drive_idle();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    load_palette();
    for (int n = 0; n < NUM_PIXELS; n++)
    begin
      @(negedge clk);
      drive_random_pixel();
    end
    @(negedge clk);
    drive_idle();
    // last pixel through both output stages
    repeat (3) @(negedge clk);
    stim_done = 1'b1;
    if (check_count == 0)
      $display("no DUT output was compared during the run");
    $display("errors: %0d, checks: %0d", error_count, check_count);
    if (error_count == 0 && check_count > 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // watchdog
  initial
  begin
    int cycles;
    cycles = 0;
    while (stim_done !== 1'b1 && cycles < WATCHDOG_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    if (stim_done !== 1'b1)
    begin
      $display("timeout: stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

// File: vout.f
+incdir+design
design/vout_pkg.sv
design/vout_src_select.sv
design/vout_palette_ram.sv
design/vout_pwm_dither.sv
design/vout_top.sv
bench/vout_checker.sv
bench/vout_tb.sv

// File: Bender.yml
package:
  name: vout

sources:
  - include_dirs:
      - design
    files:
      - design/vout_pkg.sv
      - design/vout_src_select.sv
      - design/vout_palette_ram.sv
      - design/vout_pwm_dither.sv
      - design/vout_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/vout_checker.sv
      - bench/vout_tb.sv
